//--- Makefile
TOP := issueStageTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module issueStage
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) --Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv 2>&1)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- design/csrFile.sv
`timescale 1ns/1ps
`default_nettype none

module csrFile
(
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 we,
	input  logic                 exceptionPending,
	input  rvTypesPkg::csrAddr_t readAddr,
	input  rvTypesPkg::csrAddr_t writeAddr,
	input  rvTypesPkg::word_t    writeData,
	input  rvTypesPkg::word_t    mCause,
	input  rvTypesPkg::word_t    pcExc,
	output rvTypesPkg::word_t    readData
);

	rvTypesPkg::word_t mstatus;
	rvTypesPkg::word_t mtvec;
	rvTypesPkg::word_t mscratch;
	rvTypesPkg::word_t mepc;
	rvTypesPkg::word_t mcause;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mstatus <= '0;
			mtvec <= '0;
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
		end
		else
		begin
			if (we)
			begin
				case (writeAddr)
					issueCtrlPkg::csrMstatus:  mstatus <= writeData;
					issueCtrlPkg::csrMtvec:    mtvec <= writeData;
					issueCtrlPkg::csrMscratch: mscratch <= writeData;
					issueCtrlPkg::csrMepc:     mepc <= writeData;
					issueCtrlPkg::csrMcause:   mcause <= writeData;
					default:                   mstatus <= mstatus;
				endcase
			end

			// Trap state wins over a same-edge writeback
			if (exceptionPending)
			begin
				mepc <= pcExc;
				mcause <= mCause;
			end
		end
	end

	always_comb
	begin
		case (readAddr)
			issueCtrlPkg::csrMstatus:  readData = mstatus;
			issueCtrlPkg::csrMtvec:    readData = mtvec;
			issueCtrlPkg::csrMscratch: readData = mscratch;
			issueCtrlPkg::csrMepc:     readData = mepc;
			issueCtrlPkg::csrMcause:   readData = mcause;
			default:                   readData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/hazardScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module hazardScoreboard
(
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  bjTaken,
	input  rvTypesPkg::regAddr_t  rs1,
	input  rvTypesPkg::regAddr_t  rs2,
	input  rvTypesPkg::regAddr_t  rd,
	input  issueCtrlPkg::opcode_e opcode,
	output logic                  stall,
	output logic                  kill,
	output logic [1:0]            stallNum
);

	localparam int histDepth = issueCtrlPkg::wbDistance - 1;

	typedef enum logic [1:0] {killIdle, killFirst, killSecond} killState_e;

	killState_e killState;
	logic usesRs1;
	logic usesRs2;
	logic writesRd;
	logic hazard;
	logic [1:0] hazardNum;

	// Entry 0 holds the instruction issued at the last edge
	logic                 histValid [histDepth];
	rvTypesPkg::regAddr_t histRd    [histDepth];

	// Which register fields the opcode actually uses
	always_comb
	begin
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		writesRd = 1'b0;
		case (opcode)
			issueCtrlPkg::opOp:
			begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				writesRd = 1'b1;
			end
			issueCtrlPkg::opStore,
			issueCtrlPkg::opBranch:
			begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			issueCtrlPkg::opOpImm,
			issueCtrlPkg::opLoad,
			issueCtrlPkg::opJalr,
			issueCtrlPkg::opSystem:
			begin
				usesRs1 = 1'b1;
				writesRd = 1'b1;
			end
			issueCtrlPkg::opLui,
			issueCtrlPkg::opAuipc,
			issueCtrlPkg::opJal:
				writesRd = 1'b1;
			default:
				writesRd = 1'b0;
		endcase
	end

	// Oldest first so the youngest match sets the count
	always_comb
	begin
		hazard = 1'b0;
		hazardNum = 2'd0;
		for (int i = histDepth - 1; i >= 0; i--)
		begin
			if (histValid[i] && ((usesRs1 && rs1 != '0 && rs1 == histRd[i]) ||
				(usesRs2 && rs2 != '0 && rs2 == histRd[i])))
			begin
				hazard = 1'b1;
				hazardNum = 2'(issueCtrlPkg::wbDistance - (i + 1));
			end
		end
	end

	// Killed slot is discarded, so it must not also hold decode
	assign kill = (killState == killIdle && bjTaken) || killState == killFirst;
	assign stall = hazard && !kill;
	assign stallNum = kill ? 2'd0 : hazardNum;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < histDepth; i++)
			begin
				histValid[i] <= 1'b0;
				histRd[i] <= '0;
			end
		end
		else
		begin
			histValid[0] <= writesRd && rd != '0 && !stall && !kill;
			histRd[0] <= rd;
			for (int i = 1; i < histDepth; i++)
			begin
				histValid[i] <= histValid[i-1];
				histRd[i] <= histRd[i-1];
			end
		end
	end

	// killSecond covers the cycle when execute still holds a killed slot
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			killState <= killIdle;
		else
		begin
			case (killState)
				killIdle:   killState <= bjTaken ? killFirst : killIdle;
				killFirst:  killState <= killSecond;
				killSecond: killState <= killIdle;
				default:    killState <= killIdle;
			endcase
		end
	end

	stallNumMatchesStall: assert property (@(posedge clk) disable iff (!nrst)
		(stallNum != 2'd0) == stall);

	killAtMostTwo: assert property (@(posedge clk) disable iff (!nrst)
		!(kill && $past(kill) && $past(kill, 2)));

endmodule

`default_nettype wire

//--- design/issueCtrlPkg.sv
`default_nettype none

package issueCtrlPkg;

	// Base opcodes seen by the issue stage
	typedef enum logic [6:0]
	{
		opOp     = 7'b0110011,
		opOpImm  = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opSystem = 7'b1110011
	} opcode_e;

	// Operand B source
	typedef enum logic [1:0]
	{
		bSelReg   = 2'd0,
		bSelImm   = 2'd1,
		bSelShamt = 2'd2
	} bSel_e;

	// Edges from entering stage 4 until the result is written back
	localparam int wbDistance = 3;

	// Implemented machine CSRs
	localparam rvTypesPkg::csrAddr_t csrMstatus  = 12'h300;
	localparam rvTypesPkg::csrAddr_t csrMtvec    = 12'h305;
	localparam rvTypesPkg::csrAddr_t csrMscratch = 12'h340;
	localparam rvTypesPkg::csrAddr_t csrMepc     = 12'h341;
	localparam rvTypesPkg::csrAddr_t csrMcause   = 12'h342;

endpackage

`default_nettype wire

//--- design/issuePipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module issuePipeReg
(
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   squash,
	input  logic                   we3,
	input  logic                   bneq3,
	input  logic                   btype3,
	input  logic                   j3,
	input  logic                   jr3,
	input  logic                   lui3,
	input  logic                   auipc3,
	input  logic                   misaligned3,
	input  logic                   ecall3,
	input  rvTypesPkg::regAddr_t   rd3,
	input  rvTypesPkg::aluFn_t     aluFn3,
	input  rvTypesPkg::funct3_t    fn3,
	input  rvTypesPkg::funct3_t    csrFunct3,
	input  issueCtrlPkg::bSel_e    bSel3,
	input  rvTypesPkg::word_t      iImm3,
	input  rvTypesPkg::word_t      bImm3,
	input  rvTypesPkg::word_t      jImm3,
	input  rvTypesPkg::word_t      sImm3,
	input  rvTypesPkg::word_t      uImm3,
	input  rvTypesPkg::word_t      pc3,
	input  rvTypesPkg::word_t      csrImm3,
	input  rvTypesPkg::shamt_t     shamt3,
	input  rvTypesPkg::memOp_t     memOp3,
	input  rvTypesPkg::mulDivOp_t  mulDivOp3,
	input  logic [1:0]             pcSelect3,
	input  rvTypesPkg::csrAddr_t   csrAddr3,
	input  rvTypesPkg::word_t      regA,
	input  rvTypesPkg::word_t      regB,
	output logic                   we4,
	output logic                   bneq4,
	output logic                   btype4,
	output logic                   j4,
	output logic                   jr4,
	output logic                   lui4,
	output logic                   auipc4,
	output logic                   misaligned4,
	output logic                   ecall4,
	output rvTypesPkg::regAddr_t   rd4,
	output rvTypesPkg::aluFn_t     aluFn4,
	output rvTypesPkg::funct3_t    fn4,
	output rvTypesPkg::funct3_t    csrFunct4,
	output rvTypesPkg::word_t      bImm4,
	output rvTypesPkg::word_t      jImm4,
	output rvTypesPkg::word_t      sImm4,
	output rvTypesPkg::word_t      uImm4,
	output rvTypesPkg::word_t      pc4,
	output rvTypesPkg::word_t      csrImm4,
	output rvTypesPkg::memOp_t     memOp4,
	output rvTypesPkg::mulDivOp_t  mulDivOp4,
	output logic [1:0]             pcSelect4,
	output rvTypesPkg::csrAddr_t   csrAddr4,
	output rvTypesPkg::word_t      opA,
	output rvTypesPkg::word_t      opB
);

	logic                valid4;
	issueCtrlPkg::bSel_e bSel4;
	rvTypesPkg::word_t   iImm4;
	rvTypesPkg::shamt_t  shamt4;

	// Control subset, loads bubble values on squash
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			valid4 <= 1'b0;
			we4 <= 1'b0;
			pcSelect4 <= 2'b00;
			rd4 <= '0;
			aluFn4 <= '0;
			fn4 <= '0;
			bSel4 <= issueCtrlPkg::bSelImm;
			iImm4 <= '0;
		end
		else if (squash)
		begin
			valid4 <= 1'b0;
			we4 <= 1'b0;
			pcSelect4 <= 2'b00;
			rd4 <= '0;
			aluFn4 <= '0;
			fn4 <= '0;
			bSel4 <= issueCtrlPkg::bSelImm;
			iImm4 <= '0;
		end
		else
		begin
			valid4 <= 1'b1;
			we4 <= we3;
			pcSelect4 <= pcSelect3;
			rd4 <= rd3;
			aluFn4 <= aluFn3;
			fn4 <= fn3;
			bSel4 <= bSel3;
			iImm4 <= iImm3;
		end
	end

	// Flags and op codes pass through but start cleared
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			bneq4 <= 1'b0;
			btype4 <= 1'b0;
			j4 <= 1'b0;
			jr4 <= 1'b0;
			lui4 <= 1'b0;
			auipc4 <= 1'b0;
			misaligned4 <= 1'b0;
			ecall4 <= 1'b0;
			memOp4 <= '0;
			mulDivOp4 <= '0;
		end
		else
		begin
			bneq4 <= bneq3;
			btype4 <= btype3;
			j4 <= j3;
			jr4 <= jr3;
			lui4 <= lui3;
			auipc4 <= auipc3;
			misaligned4 <= misaligned3;
			ecall4 <= ecall3;
			memOp4 <= memOp3;
			mulDivOp4 <= mulDivOp3;
		end
	end

	// Immediates, pc and CSR fields
	always_ff @(posedge clk)
	begin
		bImm4 <= bImm3;
		jImm4 <= jImm3;
		sImm4 <= sImm3;
		uImm4 <= uImm3;
		pc4 <= pc3;
		csrImm4 <= csrImm3;
		csrFunct4 <= csrFunct3;
		csrAddr4 <= csrAddr3;
		shamt4 <= shamt3;
	end

	// Register values are already stage-4 aligned
	assign opA = valid4 ? regA : '0;

	always_comb
	begin
		case (bSel4)
			issueCtrlPkg::bSelReg:   opB = regB;
			issueCtrlPkg::bSelImm:   opB = iImm4;
			issueCtrlPkg::bSelShamt: opB = {{(rvTypesPkg::xlen - 5){1'b0}}, shamt4};
			default:                 opB = regB;
		endcase
	end

endmodule

`default_nettype wire

//--- design/issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage
(
	input  logic                  clk,
	input  logic                  nrst,
	// Commit writebacks
	input  logic                  we6,
	input  rvTypesPkg::regAddr_t  rdaddr6,
	input  rvTypesPkg::word_t     wb6,
	input  logic                  csrWe,
	input  rvTypesPkg::csrAddr_t  csrWbAddr,
	input  rvTypesPkg::word_t     csrWb,
	input  logic                  exceptionPending,
	input  rvTypesPkg::word_t     mCause,
	input  rvTypesPkg::word_t     pcExc,
	input  logic                  bjTaken,
	// Stage 3 from decode
	input  rvTypesPkg::regAddr_t  rs1,
	input  rvTypesPkg::regAddr_t  rs2,
	input  issueCtrlPkg::opcode_e opcode3,
	input  logic                  we3,
	input  logic                  bneq3,
	input  logic                  btype3,
	input  logic                  j3,
	input  logic                  jr3,
	input  logic                  lui3,
	input  logic                  auipc3,
	input  logic                  misaligned3,
	input  logic                  ecall3,
	input  rvTypesPkg::regAddr_t  rd3,
	input  rvTypesPkg::aluFn_t    aluFn3,
	input  rvTypesPkg::funct3_t   fn3,
	input  rvTypesPkg::funct3_t   csrFunct3,
	input  issueCtrlPkg::bSel_e   bSel3,
	input  rvTypesPkg::word_t     iImm3,
	input  rvTypesPkg::word_t     bImm3,
	input  rvTypesPkg::word_t     jImm3,
	input  rvTypesPkg::word_t     sImm3,
	input  rvTypesPkg::word_t     uImm3,
	input  rvTypesPkg::word_t     pc3,
	input  rvTypesPkg::word_t     csrImm3,
	input  rvTypesPkg::shamt_t    shamt3,
	input  rvTypesPkg::memOp_t    memOp3,
	input  rvTypesPkg::mulDivOp_t mulDivOp3,
	input  logic [1:0]            pcSelect3,
	input  rvTypesPkg::csrAddr_t  csrAddr3,
	// Back to decode
	output logic                  stall,
	output logic [1:0]            stallNum,
	// Stage 4 to execute
	output rvTypesPkg::word_t     csrData,
	output rvTypesPkg::word_t     opA,
	output rvTypesPkg::word_t     opB,
	output logic                  we4,
	output logic                  bneq4,
	output logic                  btype4,
	output logic                  j4,
	output logic                  jr4,
	output logic                  lui4,
	output logic                  auipc4,
	output logic                  misaligned4,
	output logic                  ecall4,
	output rvTypesPkg::regAddr_t  rd4,
	output rvTypesPkg::aluFn_t    aluFn4,
	output rvTypesPkg::funct3_t   fn4,
	output rvTypesPkg::funct3_t   csrFunct4,
	output rvTypesPkg::word_t     bImm4,
	output rvTypesPkg::word_t     jImm4,
	output rvTypesPkg::word_t     sImm4,
	output rvTypesPkg::word_t     uImm4,
	output rvTypesPkg::word_t     pc4,
	output rvTypesPkg::word_t     csrImm4,
	output rvTypesPkg::memOp_t    memOp4,
	output rvTypesPkg::mulDivOp_t mulDivOp4,
	output logic [1:0]            pcSelect4,
	output rvTypesPkg::csrAddr_t  csrAddr4
);

	rvTypesPkg::word_t regA;
	rvTypesPkg::word_t regB;
	logic kill;
	logic squash;

	assign squash = stall | kill;

	regFile regFile_i
	(
		.clk       (clk),
		.nrst      (nrst),
		.we        (we6),
		.writeAddr (rdaddr6),
		.srcA      (rs1),
		.srcB      (rs2),
		.writeData (wb6),
		.rdA       (regA),
		.rdB       (regB)
	);

	hazardScoreboard hazardScoreboard_i
	(
		.clk      (clk),
		.nrst     (nrst),
		.bjTaken  (bjTaken),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd3),
		.opcode   (opcode3),
		.stall    (stall),
		.kill     (kill),
		.stallNum (stallNum)
	);

	// Read side follows the instruction now in stage 4
	csrFile csrFile_i
	(
		.clk              (clk),
		.nrst             (nrst),
		.we               (csrWe),
		.exceptionPending (exceptionPending),
		.readAddr         (csrAddr4),
		.writeAddr        (csrWbAddr),
		.writeData        (csrWb),
		.mCause           (mCause),
		.pcExc            (pcExc),
		.readData         (csrData)
	);

	issuePipeReg issuePipeReg_i
	(
		.clk         (clk),
		.nrst        (nrst),
		.squash      (squash),
		.we3         (we3),
		.bneq3       (bneq3),
		.btype3      (btype3),
		.j3          (j3),
		.jr3         (jr3),
		.lui3        (lui3),
		.auipc3      (auipc3),
		.misaligned3 (misaligned3),
		.ecall3      (ecall3),
		.rd3         (rd3),
		.aluFn3      (aluFn3),
		.fn3         (fn3),
		.csrFunct3   (csrFunct3),
		.bSel3       (bSel3),
		.iImm3       (iImm3),
		.bImm3       (bImm3),
		.jImm3       (jImm3),
		.sImm3       (sImm3),
		.uImm3       (uImm3),
		.pc3         (pc3),
		.csrImm3     (csrImm3),
		.shamt3      (shamt3),
		.memOp3      (memOp3),
		.mulDivOp3   (mulDivOp3),
		.pcSelect3   (pcSelect3),
		.csrAddr3    (csrAddr3),
		.regA        (regA),
		.regB        (regB),
		.we4         (we4),
		.bneq4       (bneq4),
		.btype4      (btype4),
		.j4          (j4),
		.jr4         (jr4),
		.lui4        (lui4),
		.auipc4      (auipc4),
		.misaligned4 (misaligned4),
		.ecall4      (ecall4),
		.rd4         (rd4),
		.aluFn4      (aluFn4),
		.fn4         (fn4),
		.csrFunct4   (csrFunct4),
		.bImm4       (bImm4),
		.jImm4       (jImm4),
		.sImm4       (sImm4),
		.uImm4       (uImm4),
		.pc4         (pc4),
		.csrImm4     (csrImm4),
		.memOp4      (memOp4),
		.mulDivOp4   (mulDivOp4),
		.pcSelect4   (pcSelect4),
		.csrAddr4    (csrAddr4),
		.opA         (opA),
		.opB         (opB)
	);

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
(
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 we,
	input  rvTypesPkg::regAddr_t writeAddr,
	input  rvTypesPkg::regAddr_t srcA,
	input  rvTypesPkg::regAddr_t srcB,
	input  rvTypesPkg::word_t    writeData,
	output rvTypesPkg::word_t    rdA,
	output rvTypesPkg::word_t    rdB
);

	// x0 has no storage
	rvTypesPkg::word_t mem [1:31];

	always_ff @(posedge clk)
	begin
		if (we && writeAddr != '0)
			mem[writeAddr] <= writeData;
	end

	// Synchronous reads, a same-edge write is passed straight through
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rdA <= '0;
			rdB <= '0;
		end
		else
		begin
			if (srcA == '0)
				rdA <= '0;
			else if (we && writeAddr == srcA)
				rdA <= writeData;
			else
				rdA <= mem[srcA];

			if (srcB == '0)
				rdB <= '0;
			else if (we && writeAddr == srcB)
				rdB <= writeData;
			else
				rdB <= mem[srcB];
		end
	end

	x0ReadsZero: assert property (@(posedge clk) disable iff (!nrst)
		($past(srcA) == '0) |-> (rdA == '0));

endmodule

`default_nettype wire

//--- design/rvTypesPkg.sv
`default_nettype none

package rvTypesPkg;

	// Datapath widths
	localparam int xlen = 32;
	localparam int regAddrW = 5;
	localparam int csrAddrW = 12;

	// Operands, immediates, pc and CSR data
	typedef logic [xlen-1:0] word_t;

	// Register file and CSR addresses
	typedef logic [regAddrW-1:0] regAddr_t;
	typedef logic [csrAddrW-1:0] csrAddr_t;

	// Operation codes carried down the pipe
	typedef logic [3:0] aluFn_t;
	typedef logic [2:0] funct3_t;
	typedef logic [3:0] memOp_t;
	typedef logic [2:0] mulDivOp_t;

	// Shift amount, zero-extended when used as operand B
	typedef logic [regAddrW-1:0] shamt_t;

endpackage

`default_nettype wire

//--- project.f
design/rvTypesPkg.sv
design/issueCtrlPkg.sv
design/regFile.sv
design/hazardScoreboard.sv
design/csrFile.sv
design/issuePipeReg.sv
design/issueStage.sv
sim/issueStageTb.sv

//--- sim/issueStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module issueStageTb;

	localparam issueCtrlPkg::opcode_e regOp = issueCtrlPkg::opOp;
	localparam issueCtrlPkg::opcode_e immOp = issueCtrlPkg::opOpImm;
	localparam issueCtrlPkg::opcode_e luiOp = issueCtrlPkg::opLui;
	localparam issueCtrlPkg::opcode_e branchOp = issueCtrlPkg::opBranch;
	localparam issueCtrlPkg::bSel_e selReg = issueCtrlPkg::bSelReg;
	localparam issueCtrlPkg::bSel_e selImm = issueCtrlPkg::bSelImm;
	localparam issueCtrlPkg::bSel_e selShamt = issueCtrlPkg::bSelShamt;
	localparam rvTypesPkg::csrAddr_t addrScratch = issueCtrlPkg::csrMscratch;
	localparam rvTypesPkg::csrAddr_t addrMtvec = issueCtrlPkg::csrMtvec;
	localparam rvTypesPkg::csrAddr_t addrMepc = issueCtrlPkg::csrMepc;
	localparam rvTypesPkg::csrAddr_t addrMcause = issueCtrlPkg::csrMcause;
	// Not a machine CSR of this design
	localparam rvTypesPkg::csrAddr_t addrNone = 12'h7c0;
	localparam int maxRows = 40;

	typedef struct {
		string                 name;
		issueCtrlPkg::opcode_e op;
		rvTypesPkg::regAddr_t  rs1;
		rvTypesPkg::regAddr_t  rs2;
		rvTypesPkg::regAddr_t  rd;
		issueCtrlPkg::bSel_e   sel;
		rvTypesPkg::csrAddr_t  csrRead;
		rvTypesPkg::regAddr_t  wbReg;
		logic                  csrW;
		rvTypesPkg::csrAddr_t  csrWAddr;
		logic                  exc;
		logic                  bj;
		logic                  expStall;
		logic [1:0]            expStallNum;
	} tableRow_t;

	// DUT signals, named as the ports
	logic clk = 1'b0;
	logic nrst;
	logic we6;
	rvTypesPkg::regAddr_t rdaddr6;
	rvTypesPkg::word_t wb6;
	logic csrWe;
	rvTypesPkg::csrAddr_t csrWbAddr;
	rvTypesPkg::word_t csrWb;
	logic exceptionPending;
	rvTypesPkg::word_t mCause;
	rvTypesPkg::word_t pcExc;
	logic bjTaken;
	rvTypesPkg::regAddr_t rs1;
	rvTypesPkg::regAddr_t rs2;
	issueCtrlPkg::opcode_e opcode3;
	logic we3, bneq3, btype3, j3, jr3, lui3, auipc3, misaligned3, ecall3;
	rvTypesPkg::regAddr_t rd3;
	rvTypesPkg::aluFn_t aluFn3;
	rvTypesPkg::funct3_t fn3;
	rvTypesPkg::funct3_t csrFunct3;
	issueCtrlPkg::bSel_e bSel3;
	rvTypesPkg::word_t iImm3, bImm3, jImm3, sImm3, uImm3, pc3, csrImm3;
	rvTypesPkg::shamt_t shamt3;
	rvTypesPkg::memOp_t memOp3;
	rvTypesPkg::mulDivOp_t mulDivOp3;
	logic [1:0] pcSelect3;
	rvTypesPkg::csrAddr_t csrAddr3;
	logic stall;
	logic [1:0] stallNum;
	rvTypesPkg::word_t csrData, opA, opB;
	logic we4, bneq4, btype4, j4, jr4, lui4, auipc4, misaligned4, ecall4;
	rvTypesPkg::regAddr_t rd4;
	rvTypesPkg::aluFn_t aluFn4;
	rvTypesPkg::funct3_t fn4;
	rvTypesPkg::funct3_t csrFunct4;
	rvTypesPkg::word_t bImm4, jImm4, sImm4, uImm4, pc4, csrImm4;
	rvTypesPkg::memOp_t memOp4;
	rvTypesPkg::mulDivOp_t mulDivOp4;
	logic [1:0] pcSelect4;
	rvTypesPkg::csrAddr_t csrAddr4;

	// Reference state
	rvTypesPkg::word_t regModel [32];
	rvTypesPkg::word_t csrModel [4096];
	tableRow_t rows [maxRows];
	int numRows;
	int errorCount;
	logic tableReady;
	logic killNext;
	logic holding;
	logic squashExp;
	logic expWe4;
	rvTypesPkg::regAddr_t expRd4;
	rvTypesPkg::word_t expOpA, expOpB, expCsr, expPc4, expUImm4;
	rvTypesPkg::memOp_t expMemOp4;

	issueStage issueStage_i (.*);

	always #4 clk = ~clk;

	task automatic checkValue(input string testName, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("** Error: %s %s expected %h actual %h", testName, field, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic logic csrImplemented(input rvTypesPkg::csrAddr_t addr);
		return addr == issueCtrlPkg::csrMstatus || addr == addrMtvec ||
			addr == addrScratch || addr == addrMepc || addr == addrMcause;
	endfunction

	task automatic addRow(input string name, input issueCtrlPkg::opcode_e op,
		input int src1, input int src2, input int dst, input issueCtrlPkg::bSel_e sel,
		input rvTypesPkg::csrAddr_t csrRead, input int wbReg, input int csrW,
		input rvTypesPkg::csrAddr_t csrWAddr, input int exc, input int bj,
		input int stallExp, input int stallNumExp);
		rows[numRows].name = name;
		rows[numRows].op = op;
		rows[numRows].rs1 = 5'(src1);
		rows[numRows].rs2 = 5'(src2);
		rows[numRows].rd = 5'(dst);
		rows[numRows].sel = sel;
		rows[numRows].csrRead = csrRead;
		rows[numRows].wbReg = 5'(wbReg);
		rows[numRows].csrW = (csrW != 0);
		rows[numRows].csrWAddr = csrWAddr;
		rows[numRows].exc = (exc != 0);
		rows[numRows].bj = (bj != 0);
		rows[numRows].expStall = (stallExp != 0);
		rows[numRows].expStallNum = 2'(stallNumExp);
		numRows++;
	endtask

	// Each row holds name, opcode, rs1, rs2, rd, bSel, CSR read address,
	// writeback register (0 for none), CSR write enable and address,
	// exception, bjTaken, expected stall and stallNum
	task automatic buildTable();
		addRow("write x1", immOp, 0, 0, 0, selImm, addrNone, 1, 0, addrNone, 0, 0, 0, 0);
		addRow("write x2", immOp, 0, 0, 0, selImm, addrNone, 2, 0, addrNone, 0, 0, 0, 0);
		addRow("write x8", immOp, 0, 0, 0, selImm, addrNone, 8, 0, addrNone, 0, 0, 0, 0);
		addRow("read x0 x1", regOp, 0, 1, 0, selReg, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("same edge bypass", regOp, 4, 2, 0, selReg, addrNone, 4, 0, addrNone, 0, 0, 0, 0);
		addRow("opB immediate", immOp, 1, 0, 0, selImm, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("opB shamt", immOp, 2, 0, 0, selShamt, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		// The instruction reading x5 is held twice
		addRow("issue x5", immOp, 1, 0, 5, selImm, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("raw age 1", regOp, 5, 2, 6, selReg, addrNone, 0, 0, addrNone, 0, 0, 1, 2);
		addRow("raw age 2", regOp, 5, 2, 6, selReg, addrNone, 0, 0, addrNone, 0, 0, 1, 1);
		addRow("raw cleared", regOp, 5, 2, 6, selReg, addrNone, 5, 0, addrNone, 0, 0, 0, 0);
		addRow("unused rs2", immOp, 1, 6, 7, selImm, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("lui no sources", luiOp, 0, 7, 0, selImm, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("write x6", immOp, 0, 0, 0, selImm, addrNone, 6, 0, addrNone, 0, 0, 0, 0);
		addRow("write x7", immOp, 0, 0, 0, selImm, addrNone, 7, 0, addrNone, 0, 0, 0, 0);
		// Taken branch kills two slots
		addRow("branch taken", branchOp, 1, 2, 0, selReg, addrNone, 0, 0, addrNone, 0, 1, 0, 0);
		addRow("killed slot", immOp, 1, 0, 8, selImm, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("after kill", regOp, 8, 1, 9, selReg, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("kill over stall", regOp, 9, 0, 0, selReg, addrNone, 0, 0, addrNone, 0, 1, 0, 0);
		addRow("second kill", regOp, 9, 0, 0, selReg, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("after 2nd kill", immOp, 0, 0, 0, selImm, addrNone, 0, 0, addrNone, 0, 0, 0, 0);
		// CSR side
		addRow("csr write", immOp, 0, 0, 0, selImm, addrScratch, 0, 1, addrScratch, 0, 0, 0, 0);
		addRow("csr read", immOp, 0, 0, 0, selImm, addrScratch, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("exception mepc", immOp, 0, 0, 0, selImm, addrMepc, 0, 1, addrMepc, 1, 0, 0, 0);
		addRow("exception mcause", immOp, 0, 0, 0, selImm, addrMcause, 0, 0, addrNone, 0, 0, 0, 0);
		addRow("csr mtvec", immOp, 0, 0, 0, selImm, addrMtvec, 0, 1, addrMtvec, 0, 0, 0, 0);
		addRow("csr unimplemented", immOp, 0, 0, 0, selImm, addrNone, 0, 1, addrNone, 0, 0, 0, 0);
	endtask

	task automatic driveRow(input int idx);
		tableRow_t r;
		logic killNow;
		r = rows[idx];
		killNow = r.bj || killNext;
		killNext = r.bj && !killNext;
		squashExp = r.expStall || killNow;

		opcode3 = r.op;
		rs1 = r.rs1;
		rs2 = r.rs2;
		rd3 = r.rd;
		we3 = !(r.op == issueCtrlPkg::opStore || r.op == branchOp);
		bSel3 = r.sel;
		csrAddr3 = r.csrRead;
		// Decode holds a stalled instruction unchanged
		if (!holding)
		begin
			iImm3 = $urandom();
			shamt3 = 5'($urandom());
			pc3 = $urandom();
			uImm3 = $urandom();
			memOp3 = 4'($urandom());
			{bneq3, btype3, j3, jr3, lui3, auipc3, misaligned3, ecall3} = 8'($urandom());
			aluFn3 = 4'($urandom());
			fn3 = 3'($urandom());
			csrFunct3 = 3'($urandom());
			bImm3 = $urandom();
			jImm3 = $urandom();
			sImm3 = $urandom();
			csrImm3 = $urandom();
			mulDivOp3 = 3'($urandom());
			pcSelect3 = 2'($urandom());
		end
		holding = r.expStall;

		we6 = (r.wbReg != '0);
		rdaddr6 = r.wbReg;
		wb6 = $urandom();
		csrWe = r.csrW;
		csrWbAddr = r.csrWAddr;
		csrWb = $urandom();
		exceptionPending = r.exc;
		pcExc = $urandom();
		mCause = $urandom();
		bjTaken = r.bj;

		// Writes at this edge are seen by the reads sampled with it
		if (we6)
			regModel[rdaddr6] = wb6;
		if (csrWe && csrImplemented(csrWbAddr))
			csrModel[csrWbAddr] = csrWb;
		if (exceptionPending)
		begin
			csrModel[addrMepc] = pcExc;
			csrModel[addrMcause] = mCause;
		end

		expWe4 = squashExp ? 1'b0 : we3;
		expRd4 = squashExp ? '0 : rd3;
		expOpA = squashExp ? '0 : regModel[rs1];
		if (squashExp)
			expOpB = '0;
		else if (bSel3 == selReg)
			expOpB = regModel[rs2];
		else if (bSel3 == selShamt)
			expOpB = {27'd0, shamt3};
		else
			expOpB = iImm3;
		expCsr = csrImplemented(csrAddr3) ? csrModel[csrAddr3] : '0;
		expPc4 = pc3;
		expUImm4 = uImm3;
		expMemOp4 = memOp3;
	endtask

	task automatic checkStage4(input string testName);
		logic [7:0] flags3;
		logic [7:0] flags4;
		flags3 = {bneq3, btype3, j3, jr3, lui3, auipc3, misaligned3, ecall3};
		flags4 = {bneq4, btype4, j4, jr4, lui4, auipc4, misaligned4, ecall4};
		checkValue(testName, "we4", 32'(expWe4), 32'(we4));
		checkValue(testName, "rd4", 32'(expRd4), 32'(rd4));
		checkValue(testName, "opA", expOpA, opA);
		checkValue(testName, "opB", expOpB, opB);
		checkValue(testName, "csrData", expCsr, csrData);
		checkValue(testName, "pc4", expPc4, pc4);
		checkValue(testName, "uImm4", expUImm4, uImm4);
		checkValue(testName, "memOp4", 32'(expMemOp4), 32'(memOp4));
		// A bubble clears these control fields
		checkValue(testName, "aluFn4", squashExp ? 32'(0) : 32'(aluFn3), 32'(aluFn4));
		checkValue(testName, "fn4", squashExp ? 32'(0) : 32'(fn3), 32'(fn4));
		checkValue(testName, "pcSelect4", squashExp ? 32'(0) : 32'(pcSelect3), 32'(pcSelect4));
		// Everything else passes through even in a bubble
		checkValue(testName, "flags4", 32'(flags3), 32'(flags4));
		checkValue(testName, "csrFunct4", 32'(csrFunct3), 32'(csrFunct4));
		checkValue(testName, "bImm4", bImm3, bImm4);
		checkValue(testName, "jImm4", jImm3, jImm4);
		checkValue(testName, "sImm4", sImm3, sImm4);
		checkValue(testName, "csrImm4", csrImm3, csrImm4);
		checkValue(testName, "mulDivOp4", 32'(mulDivOp3), 32'(mulDivOp4));
		checkValue(testName, "csrAddr4", 32'(csrAddr3), 32'(csrAddr4));
	endtask

	initial
	begin
		void'($urandom(34));
		tableReady = 1'b0;
		nrst = 1'b0;
		we6 = 1'b0;
		rdaddr6 = '0;
		wb6 = '0;
		csrWe = 1'b0;
		csrWbAddr = addrNone;
		csrWb = '0;
		exceptionPending = 1'b0;
		mCause = '0;
		pcExc = '0;
		bjTaken = 1'b0;
		rs1 = '0;
		rs2 = '0;
		opcode3 = luiOp;
		we3 = 1'b0;
		bneq3 = 1'b0;
		btype3 = 1'b0;
		j3 = 1'b0;
		jr3 = 1'b0;
		lui3 = 1'b0;
		auipc3 = 1'b0;
		misaligned3 = 1'b0;
		ecall3 = 1'b0;
		rd3 = '0;
		aluFn3 = '0;
		fn3 = '0;
		csrFunct3 = '0;
		bSel3 = selImm;
		iImm3 = '0;
		bImm3 = '0;
		jImm3 = '0;
		sImm3 = '0;
		uImm3 = '0;
		pc3 = '0;
		csrImm3 = '0;
		shamt3 = '0;
		memOp3 = '0;
		mulDivOp3 = '0;
		pcSelect3 = '0;
		csrAddr3 = addrNone;

		errorCount = 0;
		numRows = 0;
		killNext = 1'b0;
		holding = 1'b0;
		for (int i = 0; i < 32; i++)
			regModel[i] = '0;
		for (int i = 0; i < 4096; i++)
			csrModel[i] = '0;
		buildTable();
		tableReady = 1'b1;

		repeat (5) @(negedge clk);
		checkValue("reset", "stall", 32'(0), 32'(stall));
		checkValue("reset", "we4", 32'(0), 32'(we4));
		checkValue("reset", "rd4", 32'(0), 32'(rd4));
		checkValue("reset", "opA", 32'(0), opA);
		nrst = 1'b1;

		for (int i = 0; i < numRows; i++)
		begin
			driveRow(i);
			#1;
			checkValue(rows[i].name, "stall", 32'(rows[i].expStall), 32'(stall));
			checkValue(rows[i].name, "stallNum", 32'(rows[i].expStallNum), 32'(stallNum));
			@(negedge clk);
			checkStage4(rows[i].name);
		end

		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog sized from the table length plus reset and slack
	initial
	begin
		wait (tableReady === 1'b1);
		#((numRows + 20) * 8);
		$display("Watchdog expired, the run did not finish in %0d ns", (numRows + 20) * 8);
		$display("SIMULATION FAILED");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire
